// File: vram_defs.svh
`ifndef VRAM_DEFS_SVH
`define VRAM_DEFS_SVH

// memory word and nibble mask
`define VRAM_DATA_W 16
`define VRAM_MASK_W 4

// 4k words keeps simulation small
`define VRAM_ADDR_W 12
`define VRAM_DEPTH  4096

// scanline fetch pacing
`define VGEN_SLOT   4
`define LINE_WORDS  16

`endif

// File: vram_pkg.sv
package vram_pkg;

    // owner of the memory port for one cycle
    // fetch outranks host, host outranks fill
    typedef enum logic [1:0] {
        CLIENT_NONE = 2'd0,
        CLIENT_VGEN = 2'd1,
        CLIENT_HOST = 2'd2,
        CLIENT_FILL = 2'd3
    } vram_client_e;

endpackage

// File: gfx_pkg.sv
package gfx_pkg;

    // host register port command
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } host_op_e;

    // fill engine sequencing
    typedef enum logic [1:0] {
        FILL_IDLE = 2'd0,
        FILL_RUN  = 2'd1,
        FILL_DONE = 2'd2
    } fill_state_e;

endpackage

// File: vram.sv
`timescale 1ns/1ps
`include "vram_defs.svh"

module vram (
    input  logic                    clk,
    input  logic                    sel_i,
    input  logic                    wr_i,
    input  logic [`VRAM_MASK_W-1:0] wr_mask_i,
    input  logic [`VRAM_ADDR_W-1:0] addr_i,
    input  logic [`VRAM_DATA_W-1:0] data_i,
    output logic [`VRAM_DATA_W-1:0] data_o
);

    localparam int NIB_W = `VRAM_DATA_W / `VRAM_MASK_W;

    logic [`VRAM_DATA_W-1:0] mem [0:`VRAM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (sel_i) begin
            if (wr_i) begin
                // only nibbles with a set mask bit change
                for (int n = 0; n < `VRAM_MASK_W; n++) begin
                    if (wr_mask_i[n]) begin
                        mem[addr_i][n*NIB_W +: NIB_W] <= data_i[n*NIB_W +: NIB_W];
                    end
                end
            end
            // read data follows any selected access, old word on a write
            data_o <= mem[addr_i];
        end
    end

endmodule

// File: vram_arb.sv
`timescale 1ns/1ps
`include "vram_defs.svh"

module vram_arb (
    input  logic                    clk,
    input  logic                    rst_n_i,
    // scanline fetch, read only
    input  logic                    vgen_sel_i,
    input  logic [`VRAM_ADDR_W-1:0] vgen_addr_i,
    // host register port
    input  logic                    host_sel_i,
    input  logic                    host_wr_i,
    input  logic [`VRAM_MASK_W-1:0] host_wr_mask_i,
    input  logic [`VRAM_ADDR_W-1:0] host_addr_i,
    input  logic [`VRAM_DATA_W-1:0] host_data_i,
    output logic                    host_ack_o,
    // fill engine, write only
    input  logic                    fill_sel_i,
    input  logic [`VRAM_MASK_W-1:0] fill_wr_mask_i,
    input  logic [`VRAM_ADDR_W-1:0] fill_addr_i,
    input  logic [`VRAM_DATA_W-1:0] fill_data_i,
    output logic                    fill_ack_o,
    // shared read data
    output logic [`VRAM_DATA_W-1:0] vram_data_o
);

    import vram_pkg::*;

    vram_client_e            grant;
    logic                    vram_sel;
    logic                    vram_wr;
    logic [`VRAM_MASK_W-1:0] vram_wr_mask;
    logic [`VRAM_ADDR_W-1:0] vram_addr;
    logic [`VRAM_DATA_W-1:0] vram_wdata;

    // fixed priority, a client just acknowledged sits out one cycle
    always_comb begin
        if (vgen_sel_i) begin
            grant = CLIENT_VGEN;
        end else if (host_sel_i && !host_ack_o) begin
            grant = CLIENT_HOST;
        end else if (fill_sel_i && !fill_ack_o) begin
            grant = CLIENT_FILL;
        end else begin
            grant = CLIENT_NONE;
        end
    end

    always_comb begin
        vram_sel     = 1'b0;
        vram_wr      = 1'b0;
        vram_wr_mask = host_wr_mask_i;
        vram_addr    = host_addr_i;
        vram_wdata   = host_data_i;
        case (grant)
            CLIENT_VGEN: begin
                vram_sel  = 1'b1;
                vram_addr = vgen_addr_i;
            end
            CLIENT_HOST: begin
                vram_sel = 1'b1;
                vram_wr  = host_wr_i;
            end
            CLIENT_FILL: begin
                vram_sel     = 1'b1;
                vram_wr      = 1'b1;
                vram_wr_mask = fill_wr_mask_i;
                vram_addr    = fill_addr_i;
                vram_wdata   = fill_data_i;
            end
            default: begin
                vram_sel = 1'b0;
            end
        endcase
    end

    // ack lines up with the read data of the granted access
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            host_ack_o <= 1'b0;
            fill_ack_o <= 1'b0;
        end else begin
            host_ack_o <= (grant == CLIENT_HOST);
            fill_ack_o <= (grant == CLIENT_FILL);
        end
    end

    vram u_vram (
        .clk       (clk),
        .sel_i     (vram_sel),
        .wr_i      (vram_wr),
        .wr_mask_i (vram_wr_mask),
        .addr_i    (vram_addr),
        .data_i    (vram_wdata),
        .data_o    (vram_data_o)
    );

endmodule

// File: video_fetch.sv
`timescale 1ns/1ps
`include "vram_defs.svh"

module video_fetch (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    line_start_i,
    input  logic [`VRAM_ADDR_W-1:0] line_base_i,
    output logic                    vgen_sel_o,
    output logic [`VRAM_ADDR_W-1:0] vgen_addr_o,
    input  logic [`VRAM_DATA_W-1:0] vram_data_i,
    output logic                    pixel_valid_o,
    output logic [`VRAM_DATA_W-1:0] pixel_word_o
);

    localparam int SLOT_W = $clog2(`VGEN_SLOT);
    localparam int WORD_W = $clog2(`LINE_WORDS);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`VGEN_SLOT - 1);
    localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(`LINE_WORDS - 1);

    logic                    active_q;
    logic [SLOT_W-1:0]       slot_q;
    logic [WORD_W-1:0]       word_q;
    logic [`VRAM_ADDR_W-1:0] addr_q;
    logic                    rd_pend_q;

    // read on slot zero, data back next cycle, pixel the cycle after
    assign vgen_sel_o  = active_q && (slot_q == '0);
    assign vgen_addr_o = addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            active_q      <= 1'b0;
            slot_q        <= '0;
            word_q        <= '0;
            rd_pend_q     <= 1'b0;
            pixel_valid_o <= 1'b0;
        end else begin
            // a new line drops any word still in flight
            rd_pend_q     <= vgen_sel_o && !line_start_i;
            pixel_valid_o <= rd_pend_q && !line_start_i;
            if (line_start_i) begin
                active_q <= 1'b1;
                slot_q   <= '0;
                word_q   <= '0;
            end else if (active_q) begin
                slot_q <= (slot_q == LAST_SLOT) ? '0 : slot_q + 1'b1;
                if (vgen_sel_o) begin
                    word_q <= word_q + 1'b1;
                    if (word_q == LAST_WORD) begin
                        active_q <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_start_i) begin
            addr_q <= line_base_i;
        end else if (vgen_sel_o) begin
            addr_q <= addr_q + 1'b1;
        end
        if (rd_pend_q) begin
            pixel_word_o <= vram_data_i;
        end
    end

endmodule

// File: host_port.sv
`timescale 1ns/1ps
`include "vram_defs.svh"

module host_port (
    input  logic                    clk,
    input  logic                    rst_n_i,
    // command side
    input  logic                    cmd_valid_i,
    input  gfx_pkg::host_op_e       cmd_op_i,
    input  logic [`VRAM_ADDR_W-1:0] cmd_addr_i,
    input  logic [`VRAM_DATA_W-1:0] cmd_data_i,
    input  logic [`VRAM_MASK_W-1:0] cmd_mask_i,
    output logic                    busy_o,
    output logic                    rd_valid_o,
    output logic [`VRAM_DATA_W-1:0] rd_data_o,
    // arbiter side
    output logic                    host_sel_o,
    output logic                    host_wr_o,
    output logic [`VRAM_MASK_W-1:0] host_wr_mask_o,
    output logic [`VRAM_ADDR_W-1:0] host_addr_o,
    output logic [`VRAM_DATA_W-1:0] host_data_o,
    input  logic                    host_ack_i,
    input  logic [`VRAM_DATA_W-1:0] vram_data_i
);

    import gfx_pkg::*;

    logic                    busy_q;
    host_op_e                op_q;
    logic [`VRAM_ADDR_W-1:0] addr_q;
    logic [`VRAM_DATA_W-1:0] data_q;
    logic [`VRAM_MASK_W-1:0] mask_q;
    logic                    accept;

    // strobes arriving while busy are lost
    assign accept = cmd_valid_i && !busy_q;

    // request stays up through the ack cycle, the arbiter masks it there
    assign busy_o         = busy_q;
    assign host_sel_o     = busy_q;
    assign host_wr_o      = (op_q == OP_WRITE);
    assign host_wr_mask_o = mask_q;
    assign host_addr_o    = addr_q;
    assign host_data_o    = data_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= host_ack_i && (op_q == OP_READ);
            if (accept) begin
                busy_q <= 1'b1;
            end else if (host_ack_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= cmd_op_i;
            addr_q <= cmd_addr_i;
            data_q <= cmd_data_i;
            mask_q <= cmd_mask_i;
        end
        // memory word is valid alongside the ack
        if (host_ack_i && op_q == OP_READ) begin
            rd_data_o <= vram_data_i;
        end
    end

endmodule

// File: fill_engine.sv
`timescale 1ns/1ps
`include "vram_defs.svh"

module fill_engine (
    input  logic                    clk,
    input  logic                    rst_n_i,
    // command and status
    input  logic                    fill_start_i,
    input  logic [`VRAM_ADDR_W-1:0] fill_base_i,
    input  logic [`VRAM_ADDR_W:0]   fill_count_i,
    input  logic [`VRAM_DATA_W-1:0] fill_value_i,
    input  logic [`VRAM_MASK_W-1:0] fill_mask_i,
    output logic                    fill_busy_o,
    output logic                    fill_done_o,
    // arbiter side, writes only
    output logic                    fill_sel_o,
    output logic [`VRAM_MASK_W-1:0] fill_wr_mask_o,
    output logic [`VRAM_ADDR_W-1:0] fill_addr_o,
    output logic [`VRAM_DATA_W-1:0] fill_data_o,
    input  logic                    fill_ack_i
);

    import gfx_pkg::*;

    localparam int CNT_W = `VRAM_ADDR_W + 1;
    localparam logic [CNT_W-1:0] LAST_ONE = CNT_W'(1);

    fill_state_e             state_q;
    logic [`VRAM_ADDR_W-1:0] addr_q;
    logic [CNT_W-1:0]        remain_q;
    logic [`VRAM_DATA_W-1:0] value_q;
    logic [`VRAM_MASK_W-1:0] mask_q;
    logic                    launch;

    assign launch = (state_q == FILL_IDLE) && fill_start_i;

    assign fill_busy_o    = (state_q == FILL_RUN);
    assign fill_done_o    = (state_q == FILL_DONE);
    assign fill_sel_o     = (state_q == FILL_RUN);
    assign fill_wr_mask_o = mask_q;
    assign fill_addr_o    = addr_q;
    assign fill_data_o    = value_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= FILL_IDLE;
        end else begin
            case (state_q)
                FILL_IDLE: begin
                    if (fill_start_i) begin
                        // empty run reports done at once
                        state_q <= (fill_count_i == '0) ? FILL_DONE : FILL_RUN;
                    end
                end
                FILL_RUN: begin
                    if (fill_ack_i && remain_q == LAST_ONE) begin
                        state_q <= FILL_DONE;
                    end
                end
                FILL_DONE: begin
                    state_q <= FILL_IDLE;
                end
                default: begin
                    state_q <= FILL_IDLE;
                end
            endcase
        end
    end

    // step to the next word once the current write is acked
    always_ff @(posedge clk) begin
        if (launch) begin
            addr_q   <= fill_base_i;
            remain_q <= fill_count_i;
            value_q  <= fill_value_i;
            mask_q   <= fill_mask_i;
        end else if (state_q == FILL_RUN && fill_ack_i) begin
            addr_q   <= addr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
        end
    end

endmodule

// File: gfx_top.sv
`timescale 1ns/1ps
`include "vram_defs.svh"

module gfx_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    // host command port
    input  logic                    cmd_valid_i,
    input  gfx_pkg::host_op_e       cmd_op_i,
    input  logic [`VRAM_ADDR_W-1:0] cmd_addr_i,
    input  logic [`VRAM_DATA_W-1:0] cmd_data_i,
    input  logic [`VRAM_MASK_W-1:0] cmd_mask_i,
    output logic                    busy_o,
    output logic                    rd_valid_o,
    output logic [`VRAM_DATA_W-1:0] rd_data_o,
    // fill port
    input  logic                    fill_start_i,
    input  logic [`VRAM_ADDR_W-1:0] fill_base_i,
    input  logic [`VRAM_ADDR_W:0]   fill_count_i,
    input  logic [`VRAM_DATA_W-1:0] fill_value_i,
    input  logic [`VRAM_MASK_W-1:0] fill_mask_i,
    output logic                    fill_busy_o,
    output logic                    fill_done_o,
    // scanline port
    input  logic                    line_start_i,
    input  logic [`VRAM_ADDR_W-1:0] line_base_i,
    output logic                    pixel_valid_o,
    output logic [`VRAM_DATA_W-1:0] pixel_word_o
);

    logic                    vgen_sel;
    logic [`VRAM_ADDR_W-1:0] vgen_addr;
    logic                    host_sel;
    logic                    host_wr;
    logic [`VRAM_MASK_W-1:0] host_wr_mask;
    logic [`VRAM_ADDR_W-1:0] host_addr;
    logic [`VRAM_DATA_W-1:0] host_data;
    logic                    host_ack;
    logic                    fill_sel;
    logic [`VRAM_MASK_W-1:0] fill_wr_mask;
    logic [`VRAM_ADDR_W-1:0] fill_addr;
    logic [`VRAM_DATA_W-1:0] fill_data;
    logic                    fill_ack;
    logic [`VRAM_DATA_W-1:0] vram_data;

    host_port u_host_port (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_op_i       (cmd_op_i),
        .cmd_addr_i     (cmd_addr_i),
        .cmd_data_i     (cmd_data_i),
        .cmd_mask_i     (cmd_mask_i),
        .busy_o         (busy_o),
        .rd_valid_o     (rd_valid_o),
        .rd_data_o      (rd_data_o),
        .host_sel_o     (host_sel),
        .host_wr_o      (host_wr),
        .host_wr_mask_o (host_wr_mask),
        .host_addr_o    (host_addr),
        .host_data_o    (host_data),
        .host_ack_i     (host_ack),
        .vram_data_i    (vram_data)
    );

    fill_engine u_fill_engine (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fill_start_i   (fill_start_i),
        .fill_base_i    (fill_base_i),
        .fill_count_i   (fill_count_i),
        .fill_value_i   (fill_value_i),
        .fill_mask_i    (fill_mask_i),
        .fill_busy_o    (fill_busy_o),
        .fill_done_o    (fill_done_o),
        .fill_sel_o     (fill_sel),
        .fill_wr_mask_o (fill_wr_mask),
        .fill_addr_o    (fill_addr),
        .fill_data_o    (fill_data),
        .fill_ack_i     (fill_ack)
    );

    video_fetch u_video_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .line_start_i  (line_start_i),
        .line_base_i   (line_base_i),
        .vgen_sel_o    (vgen_sel),
        .vgen_addr_o   (vgen_addr),
        .vram_data_i   (vram_data),
        .pixel_valid_o (pixel_valid_o),
        .pixel_word_o  (pixel_word_o)
    );

    vram_arb u_vram_arb (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .vgen_sel_i     (vgen_sel),
        .vgen_addr_i    (vgen_addr),
        .host_sel_i     (host_sel),
        .host_wr_i      (host_wr),
        .host_wr_mask_i (host_wr_mask),
        .host_addr_i    (host_addr),
        .host_data_i    (host_data),
        .host_ack_o     (host_ack),
        .fill_sel_i     (fill_sel),
        .fill_wr_mask_i (fill_wr_mask),
        .fill_addr_i    (fill_addr),
        .fill_data_i    (fill_data),
        .fill_ack_o     (fill_ack),
        .vram_data_o    (vram_data)
    );

endmodule

// File: gfx_assertions.sv
`timescale 1ns/1ps
`include "vram_defs.svh"

module gfx_assertions (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    cmd_valid_i,
    input  gfx_pkg::host_op_e       cmd_op_i,
    input  logic [`VRAM_ADDR_W-1:0] cmd_addr_i,
    input  logic [`VRAM_DATA_W-1:0] cmd_data_i,
    input  logic [`VRAM_MASK_W-1:0] cmd_mask_i,
    input  logic                    busy_i,
    input  logic                    rd_valid_i,
    input  logic [`VRAM_DATA_W-1:0] rd_data_i,
    input  logic                    fill_start_i,
    input  logic [`VRAM_ADDR_W-1:0] fill_base_i,
    input  logic [`VRAM_ADDR_W:0]   fill_count_i,
    input  logic [`VRAM_DATA_W-1:0] fill_value_i,
    input  logic [`VRAM_MASK_W-1:0] fill_mask_i,
    input  logic                    fill_busy_i,
    input  logic                    fill_done_i,
    input  logic                    line_start_i,
    input  logic [`VRAM_ADDR_W-1:0] line_base_i,
    input  logic                    pixel_valid_i,
    input  logic [`VRAM_DATA_W-1:0] pixel_word_i
);

    import gfx_pkg::*;

    localparam int ADDR_W = `VRAM_ADDR_W;
    localparam int NIB_W  = `VRAM_DATA_W / `VRAM_MASK_W;

    int unsigned             error_count = 0;
    logic [`VRAM_DATA_W-1:0] shadow [0:`VRAM_DEPTH-1];
    logic                    host_accept;
    logic                    fill_accept;
    logic                    rd_pend_q;
    logic [`VRAM_ADDR_W-1:0] rd_addr_q;
    logic                    fill_active_q;
    logic [`VRAM_ADDR_W-1:0] pix_addr_q;
    int unsigned             pix_cnt_q;
    int unsigned             pix_gap_q;
    logic [`VRAM_DATA_W-1:0] rd_exp;
    logic [`VRAM_DATA_W-1:0] pix_exp;

    // replace the nibbles selected by the mask
    function automatic logic [`VRAM_DATA_W-1:0] merge_word(
        input logic [`VRAM_DATA_W-1:0] old_w,
        input logic [`VRAM_DATA_W-1:0] new_w,
        input logic [`VRAM_MASK_W-1:0] mask
    );
        logic [`VRAM_DATA_W-1:0] w;
        w = old_w;
        for (int n = 0; n < `VRAM_MASK_W; n++) begin
            if (mask[n]) begin
                w[n*NIB_W +: NIB_W] = new_w[n*NIB_W +: NIB_W];
            end
        end
        return w;
    endfunction

    // strobes only ever arrive while the port is idle
    assign host_accept = cmd_valid_i;
    assign fill_accept = fill_start_i;
    assign rd_exp      = shadow[rd_addr_q];
    assign pix_exp     = shadow[pix_addr_q];

    // shadow takes writes at command time
    always_ff @(posedge clk) begin
        logic [`VRAM_ADDR_W-1:0] fa;
        if (host_accept && cmd_op_i == OP_WRITE) begin
            shadow[cmd_addr_i] <= merge_word(shadow[cmd_addr_i], cmd_data_i, cmd_mask_i);
        end
        if (fill_accept) begin
            // whole run at once
            for (int i = 0; i < int'(fill_count_i); i++) begin
                fa = fill_base_i + ADDR_W'(i);
                shadow[fa] <= merge_word(shadow[fa], fill_value_i, fill_mask_i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_pend_q     <= 1'b0;
            fill_active_q <= 1'b0;
            pix_cnt_q     <= 0;
            pix_gap_q     <= 0;
        end else begin
            if (host_accept) begin
                rd_pend_q <= (cmd_op_i == OP_READ);
                rd_addr_q <= cmd_addr_i;
            end else if (rd_valid_i) begin
                rd_pend_q <= 1'b0;
            end
            if (fill_accept) begin
                fill_active_q <= 1'b1;
            end else if (fill_done_i) begin
                fill_active_q <= 1'b0;
            end
            // gap of zero means no pixel yet on this line
            if (line_start_i) begin
                pix_addr_q <= line_base_i;
                pix_cnt_q  <= 0;
                pix_gap_q  <= 0;
            end else if (pixel_valid_i) begin
                pix_addr_q <= pix_addr_q + 1'b1;
                pix_cnt_q  <= pix_cnt_q + 1;
                pix_gap_q  <= 1;
            end else if (pix_gap_q != 0) begin
                pix_gap_q <= pix_gap_q + 1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> !(busy_i || rd_valid_i || fill_busy_i || fill_done_i || pixel_valid_i))
        else begin
            error_count = error_count + 1;
            $error("mismatch reset_quiet expected %b actual %b", 5'b00000,
                   {$sampled(busy_i), $sampled(rd_valid_i), $sampled(fill_busy_i),
                    $sampled(fill_done_i), $sampled(pixel_valid_i)});
        end

    a_host_data: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_valid_i |-> rd_data_i == rd_exp)
        else begin
            error_count = error_count + 1;
            $error("mismatch host_data expected %h actual %h",
                   $sampled(rd_exp), $sampled(rd_data_i));
        end

    a_rd_valid_once: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_valid_i |-> rd_pend_q)
        else begin
            error_count = error_count + 1;
            $error("mismatch rd_valid_once expected %b actual %b", 1'b0, 1'b1);
        end

    // a finished read must have produced its strobe
    a_rd_valid_seen: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(busy_i) |-> rd_valid_i == rd_pend_q)
        else begin
            error_count = error_count + 1;
            $error("mismatch rd_valid_seen expected %b actual %b",
                   $sampled(rd_pend_q), $sampled(rd_valid_i));
        end

    a_fill_done_once: assert property (@(posedge clk) disable iff (!rst_n_i)
        fill_done_i |-> fill_active_q)
        else begin
            error_count = error_count + 1;
            $error("mismatch fill_done_once expected %b actual %b", 1'b0, 1'b1);
        end

    // busy from the cycle after start up to the done pulse
    a_fill_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        fill_busy_i == (fill_active_q && !fill_done_i))
        else begin
            error_count = error_count + 1;
            $error("mismatch fill_busy expected %b actual %b",
                   $sampled(fill_active_q && !fill_done_i), $sampled(fill_busy_i));
        end

    a_pixel_data: assert property (@(posedge clk) disable iff (!rst_n_i)
        pixel_valid_i |-> pixel_word_i == pix_exp)
        else begin
            error_count = error_count + 1;
            $error("mismatch pixel_data expected %h actual %h",
                   $sampled(pix_exp), $sampled(pixel_word_i));
        end

    a_pixel_count: assert property (@(posedge clk) disable iff (!rst_n_i)
        pixel_valid_i |-> pix_cnt_q < `LINE_WORDS)
        else begin
            error_count = error_count + 1;
            $error("mismatch pixel_count expected below %0d actual %0d",
                   `LINE_WORDS, $sampled(pix_cnt_q) + 1);
        end

    a_pixel_spacing: assert property (@(posedge clk) disable iff (!rst_n_i)
        pixel_valid_i && pix_cnt_q != 0 |-> pix_gap_q == `VGEN_SLOT)
        else begin
            error_count = error_count + 1;
            $error("mismatch pixel_spacing expected %0d actual %0d",
                   `VGEN_SLOT, $sampled(pix_gap_q));
        end

endmodule

bind gfx_top gfx_assertions u_checker (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_op_i      (cmd_op_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_data_i    (cmd_data_i),
    .cmd_mask_i    (cmd_mask_i),
    .busy_i        (busy_o),
    .rd_valid_i    (rd_valid_o),
    .rd_data_i     (rd_data_o),
    .fill_start_i  (fill_start_i),
    .fill_base_i   (fill_base_i),
    .fill_count_i  (fill_count_i),
    .fill_value_i  (fill_value_i),
    .fill_mask_i   (fill_mask_i),
    .fill_busy_i   (fill_busy_o),
    .fill_done_i   (fill_done_o),
    .line_start_i  (line_start_i),
    .line_base_i   (line_base_i),
    .pixel_valid_i (pixel_valid_o),
    .pixel_word_i  (pixel_word_o)
);

// File: tb_gfx_top.sv
`timescale 1ns/1ps
`include "vram_defs.svh"

module tb_gfx_top;

    import gfx_pkg::*;

    localparam int ADDR_W     = `VRAM_ADDR_W;
    localparam int DATA_W     = `VRAM_DATA_W;
    localparam int MASK_W     = `VRAM_MASK_W;
    localparam int CNT_W      = `VRAM_ADDR_W + 1;
    localparam int WAIT_LIMIT = 400;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                cmd_valid;
    host_op_e            cmd_op;
    logic [ADDR_W-1:0]   cmd_addr;
    logic [DATA_W-1:0]   cmd_data;
    logic [MASK_W-1:0]   cmd_mask;
    logic                busy;
    logic                rd_valid;
    logic [DATA_W-1:0]   rd_data;
    logic                fill_start;
    logic [ADDR_W-1:0]   fill_base;
    logic [CNT_W-1:0]    fill_count;
    logic [DATA_W-1:0]   fill_value;
    logic [MASK_W-1:0]   fill_mask;
    logic                fill_busy;
    logic                fill_done;
    logic                line_start;
    logic [ADDR_W-1:0]   line_base;
    logic                pixel_valid;
    logic [DATA_W-1:0]   pixel_word;
    int unsigned         timeout_count = 0;

    gfx_top u_gfx_top (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .cmd_valid_i   (cmd_valid),
        .cmd_op_i      (cmd_op),
        .cmd_addr_i    (cmd_addr),
        .cmd_data_i    (cmd_data),
        .cmd_mask_i    (cmd_mask),
        .busy_o        (busy),
        .rd_valid_o    (rd_valid),
        .rd_data_o     (rd_data),
        .fill_start_i  (fill_start),
        .fill_base_i   (fill_base),
        .fill_count_i  (fill_count),
        .fill_value_i  (fill_value),
        .fill_mask_i   (fill_mask),
        .fill_busy_o   (fill_busy),
        .fill_done_o   (fill_done),
        .line_start_i  (line_start),
        .line_base_i   (line_base),
        .pixel_valid_o (pixel_valid),
        .pixel_word_o  (pixel_word)
    );

    always #50 clk = ~clk;

    // preload contents, unique per address
    function automatic logic [DATA_W-1:0] pattern_word(input logic [ADDR_W-1:0] a);
        return {a[3:0], a} ^ 16'h5a3c;
    endfunction

    task automatic host_access(input host_op_e op, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data, input logic [MASK_W-1:0] mask);
        int n;
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_addr  <= addr;
        cmd_data  <= data;
        cmd_mask  <= mask;
        @(posedge clk);
        cmd_valid <= 1'b0;
        n = 0;
        // reads end on rd_valid, writes on busy falling
        @(negedge clk);
        while ((op == OP_READ) ? !rd_valid : busy) begin
            if (n == WAIT_LIMIT) begin
                timeout_count++;
                $display("timeout: host %s at address %h never finished",
                         (op == OP_READ) ? "read" : "write", addr);
                break;
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic run_fill(input logic [ADDR_W-1:0] base, input logic [CNT_W-1:0] count,
                            input logic [DATA_W-1:0] value, input logic [MASK_W-1:0] mask);
        int n;
        @(posedge clk);
        fill_start <= 1'b1;
        fill_base  <= base;
        fill_count <= count;
        fill_value <= value;
        fill_mask  <= mask;
        @(posedge clk);
        fill_start <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!fill_done) begin
            if (n == WAIT_LIMIT + 4 * int'(count)) begin
                timeout_count++;
                $display("timeout: fill of %0d words at %h never reported done", count, base);
                break;
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic start_line(input logic [ADDR_W-1:0] base);
        @(posedge clk);
        line_start <= 1'b1;
        line_base  <= base;
        @(posedge clk);
        line_start <= 1'b0;
    endtask

    task automatic fetch_line(input logic [ADDR_W-1:0] base);
        int n;
        int seen;
        start_line(base);
        n = 0;
        seen = 0;
        while (seen < `LINE_WORDS) begin
            @(negedge clk);
            if (pixel_valid) begin
                seen++;
            end
            if (n == WAIT_LIMIT) begin
                timeout_count++;
                $display("timeout: line at %h gave only %0d pixels", base, seen);
                break;
            end
            n++;
        end
        // leave room for a stray extra pixel
        repeat (2 * `VGEN_SLOT) @(posedge clk);
    endtask

    initial begin
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        logic [MASK_W-1:0] m;
        logic [CNT_W-1:0]  cnt;
        logic [ADDR_W-1:0] ha;
        logic [DATA_W-1:0] fv;
        logic [MASK_W-1:0] fm;
        int unsigned       check_errors;

        void'($urandom(32'hf335_c355));
        rst_n      <= 1'b0;
        cmd_valid  <= 1'b0;
        cmd_op     <= OP_READ;
        cmd_addr   <= '0;
        cmd_data   <= '0;
        cmd_mask   <= '0;
        fill_start <= 1'b0;
        fill_base  <= '0;
        fill_count <= '0;
        fill_value <= '0;
        fill_mask  <= '0;
        line_start <= 1'b0;
        line_base  <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // every word gets a known value first
        for (int i = 0; i < `VRAM_DEPTH; i++) begin
            host_access(OP_WRITE, ADDR_W'(i), pattern_word(ADDR_W'(i)), 4'hf);
        end

        // masked host writes read back
        for (int k = 0; k < 24; k++) begin
            a = ADDR_W'($urandom);
            d = DATA_W'($urandom);
            m = MASK_W'($urandom);
            host_access(OP_READ, a, '0, '0);
            host_access(OP_WRITE, a, d, m);
            host_access(OP_READ, a, '0, '0);
        end

        // fills, first one empty, then inside and both edges
        for (int k = 0; k < 4; k++) begin
            a   = ADDR_W'($urandom);
            cnt = (k == 0) ? '0 : CNT_W'(1 + $urandom % 48);
            d   = DATA_W'($urandom);
            m   = MASK_W'($urandom);
            run_fill(a, cnt, d, m);
            if (cnt != 0) begin
                host_access(OP_READ, a + ADDR_W'($urandom % 32'(cnt)), '0, '0);
            end
            host_access(OP_READ, a - 1'b1, '0, '0);
            host_access(OP_READ, a + ADDR_W'(cnt), '0, '0);
        end

        for (int k = 0; k < 3; k++) begin
            fetch_line(ADDR_W'($urandom));
        end

        // all three clients at once on separate regions
        fv = DATA_W'($urandom);
        fm = MASK_W'($urandom);
        fork
            run_fill(12'h100, 13'd200, fv, fm);
            begin
                for (int k = 0; k < 30; k++) begin
                    ha = 12'h800 + ADDR_W'($urandom % 256);
                    host_access(OP_WRITE, ha, DATA_W'($urandom), MASK_W'($urandom));
                    host_access(OP_READ, ha, '0, '0);
                end
            end
            begin
                start_line(12'hc00);
                repeat (10) @(posedge clk);
                for (int k = 0; k < 3; k++) begin
                    fetch_line(12'hc10 + ADDR_W'(16 * k));
                end
            end
        join

        // fill region after the contention
        fetch_line(12'h100);
        for (int k = 0; k < 4; k++) begin
            host_access(OP_READ, 12'h100 + ADDR_W'($urandom % 200), '0, '0);
        end

        repeat (4) @(posedge clk);
        check_errors = u_gfx_top.u_checker.error_count;
        $display("closing: %0d assertion failures, %0d timeouts", check_errors, timeout_count);
        if (check_errors == 0 && timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+.
vram_pkg.sv
gfx_pkg.sv
vram.sv
vram_arb.sv
video_fetch.sv
host_port.sv
fill_engine.sv
gfx_top.sv
gfx_assertions.sv
tb_gfx_top.sv

// File: Makefile
TOP := tb_gfx_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

# the error limit lets the run reach its closing line after assertion failures
run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f src.f --top-module $(TOP)
	verilator --lint-only -Wall -f src.f --top-module gfx_top

clean:
	rm -rf obj_dir sim.log
